/* include/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ==========================================================
// Core sizing
// ==========================================================

// Hart count, power of two and at least 4 so each hart has one slot in flight
`define NUM_HARTS 4

// Integer register and data path width
`define XLEN 32

// Instruction and data memory depths in 32-bit words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// Byte distance between the start addresses of neighbouring harts
`define HART_PC_STRIDE 64

// Start address of hart 0
`define RESET_PC 0

`endif

/* src/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // ==========================================================
    // Major opcodes of the supported subset
    // ==========================================================
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // ==========================================================
    // Instruction formats, msb first, 32 bits each
    // ==========================================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    // Branch offset is scrambled over two fields
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One fetched word, viewed in the format its opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // Decoded operation, NOP covers every unsupported encoding
    typedef enum logic [3:0] {
        UOP_NOP,
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLT,
        UOP_ADDI,
        UOP_LUI,
        UOP_LW,
        UOP_SW,
        UOP_BEQ,
        UOP_BNE,
        UOP_JAL
    } uop_e;

endpackage

`default_nettype wire

/* src/core_pkg.sv */
`default_nettype none

`include "core_consts.svh"

package core_pkg;

    // ==========================================================
    // Scalar types
    // ==========================================================
    typedef logic [$clog2(`NUM_HARTS)-1:0]  hart_t;
    typedef logic [`XLEN-1:0]               word_t;
    typedef logic [4:0]                     reg_idx_t;
    typedef logic [$clog2(`IMEM_WORDS)-1:0] imem_addr_t;
    typedef logic [$clog2(`DMEM_WORDS)-1:0] dmem_addr_t;

    // ==========================================================
    // Stage bundles
    // ==========================================================
    // Fetch to decode
    typedef struct packed {
        logic               valid;
        hart_t              hart;
        word_t              pc;
        rv_isa_pkg::instr_u instr;
    } fetch_t;

    // Decode to execute, operands already read
    typedef struct packed {
        logic             valid;
        hart_t            hart;
        word_t            pc;
        rv_isa_pkg::uop_e uop;
        reg_idx_t         rd;
        word_t            rs1_val;
        word_t            rs2_val;
        word_t            imm;
    } dx_t;

    // Execute back to fetch
    typedef struct packed {
        logic  valid;
        hart_t hart;
        word_t pc;
    } pc_upd_t;

    // Pipeline side of the data memory
    typedef struct packed {
        logic       we;
        dmem_addr_t addr;
        word_t      wdata;
    } dmem_req_t;

    // Execute to writeback
    typedef struct packed {
        logic     valid;
        hart_t    hart;
        reg_idx_t rd;
        logic     wen;
        logic     is_load;
        word_t    result;
    } xw_t;

    // One register write as seen from outside
    typedef struct packed {
        hart_t    hart;
        reg_idx_t rd;
        word_t    value;
    } retire_t;

endpackage

`default_nettype wire

/* src/fetch_unit.sv */
`default_nettype none

`include "core_consts.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 prog_mode,
    input  logic                 imem_we,
    input  core_pkg::imem_addr_t imem_addr,
    input  core_pkg::word_t      imem_wdata,
    input  core_pkg::pc_upd_t    pc_upd,
    output core_pkg::fetch_t     fetch
);

    // ==========================================================
    // Hart rotation and program counters
    // ==========================================================
    core_pkg::hart_t      hart_cnt;
    core_pkg::word_t      pc [`NUM_HARTS];
    core_pkg::imem_addr_t imem_rd_addr;

    // Slot bookkeeping that travels with the memory read
    logic                 slot_valid;
    core_pkg::hart_t      slot_hart;
    core_pkg::word_t      slot_pc;
    core_pkg::word_t      imem [`IMEM_WORDS];
    rv_isa_pkg::instr_u   instr_q;

    // Byte PC to word index
    assign imem_rd_addr = pc[hart_cnt][2 +: $bits(core_pkg::imem_addr_t)];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hart_cnt   <= '0;
            slot_valid <= 1'b0;
            slot_hart  <= '0;
            slot_pc    <= '0;
            // Each hart starts in its own window
            for (int i = 0; i < `NUM_HARTS; i++) begin
                pc[i] <= core_pkg::word_t'(`RESET_PC + i * `HART_PC_STRIDE);
            end
        end else begin
            // Counter wraps on its own, hart count is a power of two
            hart_cnt   <= hart_cnt + 1'b1;
            // Bubbles while the memories are being loaded
            slot_valid <= !prog_mode;
            slot_hart  <= hart_cnt;
            slot_pc    <= pc[hart_cnt];
            // Returning hart arrives one slot before its next turn
            if (pc_upd.valid) begin
                pc[pc_upd.hart] <= pc_upd.pc;
            end
        end
    end

    // ==========================================================
    // Instruction memory, external write and synchronous read
    // ==========================================================
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
        instr_q <= imem[imem_rd_addr];
    end

    assign fetch = '{valid: slot_valid, hart: slot_hart, pc: slot_pc, instr: instr_q};

    // Execute must never rewrite the PC of the hart in the fetch slot
    a_pc_upd_other_hart : assert property (
        @(posedge clk) disable iff (!arst_n)
        pc_upd.valid |-> pc_upd.hart != hart_cnt
    );

endmodule

`default_nettype wire

/* src/hart_regfile.sv */
`default_nettype none

`include "core_consts.svh"

module hart_regfile (
    input  logic               clk,
    input  core_pkg::hart_t    rd_hart,
    input  core_pkg::reg_idx_t ra1,
    input  core_pkg::reg_idx_t ra2,
    output core_pkg::word_t    rd1,
    output core_pkg::word_t    rd2,
    input  core_pkg::hart_t    wr_hart,
    input  logic               wen,
    input  core_pkg::reg_idx_t wa,
    input  core_pkg::word_t    wd
);

    // One bank of 32 registers per hart
    core_pkg::word_t regs [`NUM_HARTS][32];

    // Single write port, driven from writeback
    always_ff @(posedge clk) begin
        if (wen) begin
            regs[wr_hart][wa] <= wd;
        end
    end

    // Combinational reads, x0 is hardwired to zero
    assign rd1 = (ra1 == '0) ? '0 : regs[rd_hart][ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[rd_hart][ra2];

    // Barrel spacing keeps decode and writeback on different harts
    a_no_same_hart_rw : assert property (
        @(posedge clk) wen |-> wr_hart != rd_hart
    );

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  core_pkg::fetch_t   fetch,
    output core_pkg::reg_idx_t rf_ra1,
    output core_pkg::reg_idx_t rf_ra2,
    output core_pkg::hart_t    rf_hart,
    input  core_pkg::word_t    rf_rd1,
    input  core_pkg::word_t    rf_rd2,
    output core_pkg::dx_t      dx
);

    rv_isa_pkg::instr_u ins;
    rv_isa_pkg::uop_e   uop;
    core_pkg::word_t    imm;

    assign ins = fetch.instr;

    // Source fields sit at the same place in every format
    assign rf_ra1  = ins.r.rs1;
    assign rf_ra2  = ins.r.rs2;
    assign rf_hart = fetch.hart;

    // ==========================================================
    // Operation and immediate per format
    // ==========================================================
    always_comb begin
        uop = rv_isa_pkg::UOP_NOP;
        imm = '0;
        case (ins.r.opcode)
            rv_isa_pkg::OPC_OP: begin
                // funct7 and funct3 together
                case ({ins.r.funct7, ins.r.funct3})
                    10'b0000000_000: uop = rv_isa_pkg::UOP_ADD;
                    10'b0100000_000: uop = rv_isa_pkg::UOP_SUB;
                    10'b0000000_010: uop = rv_isa_pkg::UOP_SLT;
                    10'b0000000_100: uop = rv_isa_pkg::UOP_XOR;
                    10'b0000000_110: uop = rv_isa_pkg::UOP_OR;
                    10'b0000000_111: uop = rv_isa_pkg::UOP_AND;
                    default:         uop = rv_isa_pkg::UOP_NOP;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                if (ins.i.funct3 == 3'b000) begin
                    uop = rv_isa_pkg::UOP_ADDI;
                end
                imm = {{20{ins.i.imm[11]}}, ins.i.imm};
            end
            rv_isa_pkg::OPC_LUI: begin
                uop = rv_isa_pkg::UOP_LUI;
                imm = {ins.u.imm_31_12, 12'b0};
            end
            rv_isa_pkg::OPC_LOAD: begin
                // Word loads only
                if (ins.i.funct3 == 3'b010) begin
                    uop = rv_isa_pkg::UOP_LW;
                end
                imm = {{20{ins.i.imm[11]}}, ins.i.imm};
            end
            rv_isa_pkg::OPC_STORE: begin
                if (ins.s.funct3 == 3'b010) begin
                    uop = rv_isa_pkg::UOP_SW;
                end
                imm = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
            end
            rv_isa_pkg::OPC_BRANCH: begin
                if (ins.b.funct3 == 3'b000) begin
                    uop = rv_isa_pkg::UOP_BEQ;
                end else if (ins.b.funct3 == 3'b001) begin
                    uop = rv_isa_pkg::UOP_BNE;
                end
                imm = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
                       ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
            end
            rv_isa_pkg::OPC_JAL: begin
                uop = rv_isa_pkg::UOP_JAL;
                imm = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12,
                       ins.j.imm_11, ins.j.imm_10_1, 1'b0};
            end
            default: begin
                uop = rv_isa_pkg::UOP_NOP;
            end
        endcase
    end

    // Decode to execute register, captures operands
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dx <= '0;
        end else begin
            dx <= '{valid: fetch.valid, hart: fetch.hart, pc: fetch.pc, uop: uop,
                    rd: ins.r.rd, rs1_val: rf_rd1, rs2_val: rf_rd2, imm: imm};
        end
    end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  core_pkg::dx_t       dx,
    output core_pkg::pc_upd_t   pc_upd,
    output core_pkg::dmem_req_t dmem_req,
    output core_pkg::xw_t       xw
);

    logic            reg_src;
    logic            taken;
    logic            writes;
    core_pkg::word_t op_b;
    core_pkg::word_t alu_res;
    core_pkg::word_t pc_plus4;
    core_pkg::word_t next_pc;

    // ==========================================================
    // ALU
    // ==========================================================
    // Register-register forms take rs2, the rest take the immediate
    assign reg_src = dx.uop inside {rv_isa_pkg::UOP_ADD, rv_isa_pkg::UOP_SUB,
                                    rv_isa_pkg::UOP_AND, rv_isa_pkg::UOP_OR,
                                    rv_isa_pkg::UOP_XOR, rv_isa_pkg::UOP_SLT};
    assign op_b    = reg_src ? dx.rs2_val : dx.imm;

    always_comb begin
        case (dx.uop)
            rv_isa_pkg::UOP_ADD,
            rv_isa_pkg::UOP_ADDI,
            rv_isa_pkg::UOP_LW,
            rv_isa_pkg::UOP_SW:  alu_res = dx.rs1_val + op_b;
            rv_isa_pkg::UOP_SUB: alu_res = dx.rs1_val - op_b;
            rv_isa_pkg::UOP_AND: alu_res = dx.rs1_val & op_b;
            rv_isa_pkg::UOP_OR:  alu_res = dx.rs1_val | op_b;
            rv_isa_pkg::UOP_XOR: alu_res = dx.rs1_val ^ op_b;
            rv_isa_pkg::UOP_SLT: begin
                alu_res = ($signed(dx.rs1_val) < $signed(op_b)) ? 32'd1 : 32'd0;
            end
            rv_isa_pkg::UOP_LUI: alu_res = dx.imm;
            default:             alu_res = '0;
        endcase
    end

    // ==========================================================
    // Branch compare and next PC
    // ==========================================================
    assign taken = (dx.uop == rv_isa_pkg::UOP_JAL) ||
                   ((dx.uop == rv_isa_pkg::UOP_BEQ) && (dx.rs1_val == dx.rs2_val)) ||
                   ((dx.uop == rv_isa_pkg::UOP_BNE) && (dx.rs1_val != dx.rs2_val));
    assign pc_plus4 = dx.pc + 32'd4;
    assign next_pc  = taken ? dx.pc + dx.imm : pc_plus4;

    // Operations that produce a register value
    assign writes = dx.uop inside {rv_isa_pkg::UOP_ADD, rv_isa_pkg::UOP_SUB,
                                   rv_isa_pkg::UOP_AND, rv_isa_pkg::UOP_OR,
                                   rv_isa_pkg::UOP_XOR, rv_isa_pkg::UOP_SLT,
                                   rv_isa_pkg::UOP_ADDI, rv_isa_pkg::UOP_LUI,
                                   rv_isa_pkg::UOP_LW, rv_isa_pkg::UOP_JAL};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_upd   <= '0;
            dmem_req <= '0;
            xw       <= '0;
        end else begin
            // Every valid slot returns a PC, NOP included
            pc_upd   <= '{valid: dx.valid, hart: dx.hart, pc: next_pc};
            // Byte address to word index, also the load address
            dmem_req <= '{we: dx.valid && (dx.uop == rv_isa_pkg::UOP_SW),
                          addr: alu_res[2 +: $bits(core_pkg::dmem_addr_t)],
                          wdata: dx.rs2_val};
            xw       <= '{valid: dx.valid, hart: dx.hart, rd: dx.rd,
                          wen: writes && (dx.rd != '0),
                          is_load: dx.uop == rv_isa_pkg::UOP_LW,
                          result: (dx.uop == rv_isa_pkg::UOP_JAL) ? pc_plus4 : alu_res};
        end
    end

endmodule

`default_nettype wire

/* src/data_mem.sv */
`default_nettype none

`include "core_consts.svh"

module data_mem (
    input  logic                 clk,
    input  logic                 prog_mode,
    input  logic                 io_we,
    input  core_pkg::dmem_addr_t io_addr,
    input  core_pkg::word_t      io_wdata,
    input  core_pkg::dmem_req_t  req,
    output core_pkg::word_t      rdata
);

    core_pkg::word_t      mem [`DMEM_WORDS];
    logic                 wr_en;
    core_pkg::dmem_addr_t wr_addr;
    core_pkg::word_t      wr_data;

    // ==========================================================
    // Write arbiter, outside port owns the array in program mode
    // ==========================================================
    always_comb begin
        if (prog_mode) begin
            wr_en   = io_we;
            wr_addr = io_addr;
            wr_data = io_wdata;
        end else begin
            wr_en   = req.we;
            wr_addr = req.addr;
            wr_data = req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Address register lives in execute, data is ready one cycle after the request
    // A same-address write lands at the edge, so the old word is returned
    assign rdata = mem[req.addr];

    // Fetch bubbles in program mode, so no store may reach the arbiter then
    a_no_store_in_program : assert property (
        @(posedge clk) prog_mode |-> !req.we
    );

endmodule

`default_nettype wire

/* src/writeback_stage.sv */
`default_nettype none

module writeback_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  core_pkg::xw_t      xw,
    input  core_pkg::word_t    rdata,
    output core_pkg::hart_t    rf_hart,
    output logic               rf_wen,
    output core_pkg::reg_idx_t rf_wa,
    output core_pkg::word_t    rf_wd,
    output logic               retire_valid,
    output core_pkg::retire_t  retire
);

    // Load data or execute result
    assign rf_hart = xw.hart;
    assign rf_wa   = xw.rd;
    assign rf_wd   = xw.is_load ? rdata : xw.result;
    // rd of x0 already cleared wen in execute
    assign rf_wen  = xw.valid && xw.wen;

    // ==========================================================
    // Retire port, one record per register write
    // ==========================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= rf_wen;
        end
    end

    always_ff @(posedge clk) begin
        retire <= '{hart: rf_hart, rd: rf_wa, value: rf_wd};
    end

endmodule

`default_nettype wire

/* src/barrel_core_top.sv */
`default_nettype none

module barrel_core_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 prog_mode,
    input  logic                 imem_we,
    input  core_pkg::imem_addr_t imem_addr,
    input  core_pkg::word_t      imem_wdata,
    input  logic                 dmem_we,
    input  core_pkg::dmem_addr_t dmem_addr,
    input  core_pkg::word_t      dmem_wdata,
    output logic                 retire_valid,
    output core_pkg::retire_t    retire
);

    // ==========================================================
    // Stage bundles
    // ==========================================================
    core_pkg::fetch_t    fetch;
    core_pkg::dx_t       dx;
    core_pkg::pc_upd_t   pc_upd;
    core_pkg::dmem_req_t dmem_req;
    core_pkg::xw_t       xw;
    core_pkg::word_t     dmem_rdata;

    // Register file read side, decode
    core_pkg::reg_idx_t  rf_ra1;
    core_pkg::reg_idx_t  rf_ra2;
    core_pkg::hart_t     rf_rd_hart;
    core_pkg::word_t     rf_rd1;
    core_pkg::word_t     rf_rd2;

    // Register file write side, writeback
    core_pkg::hart_t     rf_wr_hart;
    logic                rf_wen;
    core_pkg::reg_idx_t  rf_wa;
    core_pkg::word_t     rf_wd;

    fetch_unit i_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .prog_mode  (prog_mode),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .pc_upd     (pc_upd),
        .fetch      (fetch)
    );

    hart_regfile i_regfile (
        .clk     (clk),
        .rd_hart (rf_rd_hart),
        .ra1     (rf_ra1),
        .ra2     (rf_ra2),
        .rd1     (rf_rd1),
        .rd2     (rf_rd2),
        .wr_hart (rf_wr_hart),
        .wen     (rf_wen),
        .wa      (rf_wa),
        .wd      (rf_wd)
    );

    decode_stage i_decode (
        .clk     (clk),
        .arst_n  (arst_n),
        .fetch   (fetch),
        .rf_ra1  (rf_ra1),
        .rf_ra2  (rf_ra2),
        .rf_hart (rf_rd_hart),
        .rf_rd1  (rf_rd1),
        .rf_rd2  (rf_rd2),
        .dx      (dx)
    );

    execute_stage i_execute (
        .clk      (clk),
        .arst_n   (arst_n),
        .dx       (dx),
        .pc_upd   (pc_upd),
        .dmem_req (dmem_req),
        .xw       (xw)
    );

    // Program port and execute share this memory
    data_mem i_dmem (
        .clk       (clk),
        .prog_mode (prog_mode),
        .io_we     (dmem_we),
        .io_addr   (dmem_addr),
        .io_wdata  (dmem_wdata),
        .req       (dmem_req),
        .rdata     (dmem_rdata)
    );

    writeback_stage i_writeback (
        .clk          (clk),
        .arst_n       (arst_n),
        .xw           (xw),
        .rdata        (dmem_rdata),
        .rf_hart      (rf_wr_hart),
        .rf_wen       (rf_wen),
        .rf_wa        (rf_wa),
        .rf_wd        (rf_wd),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

/* verification/tb_barrel_core.sv */
`default_nettype none

`include "core_consts.svh"

module tb_barrel_core;

    localparam int    clk_period   = 40;
    localparam int    drive_dly    = 2;
    localparam int    reset_cycles = 5;
    localparam string data_file    = "verification/barrel_core_testdata.txt";

    // One memory write taken from the data file
    typedef struct packed {
        logic            is_imem;
        core_pkg::word_t addr;
        core_pkg::word_t data;
    } load_t;

    // ==========================================================
    // DUT signals
    // ==========================================================
    logic                 clk;
    logic                 arst_n;
    logic                 prog_mode;
    logic                 imem_we;
    core_pkg::imem_addr_t imem_addr;
    core_pkg::word_t      imem_wdata;
    logic                 dmem_we;
    core_pkg::dmem_addr_t dmem_addr;
    core_pkg::word_t      dmem_wdata;
    logic                 retire_valid;
    core_pkg::retire_t    retire;

    // Load list and per-hart expected retire records
    load_t             load_q [$];
    core_pkg::retire_t exp_q [`NUM_HARTS][$];
    int                n_exp;
    int                cycle_cnt;
    int                cycle_limit;
    int                slot_cnt;
    int                last_retire [`NUM_HARTS];
    int                mismatch_cnt;
    int                protocol_cnt;
    int                missing_cnt;

    // Ports in declaration order of barrel_core_top
    barrel_core_top i_dut (
        clk,
        arst_n,
        prog_mode,
        imem_we,
        imem_addr,
        imem_wdata,
        dmem_we,
        dmem_addr,
        dmem_wdata,
        retire_valid,
        retire
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Fetch slot number, slot t belongs to hart t mod NUM_HARTS
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_cnt <= 0;
        end else begin
            slot_cnt <= slot_cnt + 1;
        end
    end

    // ==========================================================
    // Data file parsing and memory loading
    // ==========================================================
    task automatic read_testdata();
        int                fd;
        int                n;
        string             line;
        byte               tag;
        logic [31:0]       f1;
        logic [31:0]       f2;
        logic [31:0]       f3;
        load_t             ld;
        core_pkg::retire_t rec;
        fd = $fopen(data_file, "r");
        if (fd == 0) begin
            $display("Could not open the data file %s", data_file);
            protocol_cnt++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            tag = line.getc(0);
            n   = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", f1, f2, f3);
            if (tag == "I" || tag == "D") begin
                if (n < 2) begin
                    $display("Malformed memory line in the data file: %s", line);
                    protocol_cnt++;
                end else begin
                    ld = '{is_imem: tag == "I", addr: f1, data: f2};
                    load_q.push_back(ld);
                end
            end else if (tag == "E") begin
                if (n < 3 || f1 >= `NUM_HARTS) begin
                    $display("Malformed expected record in the data file: %s", line);
                    protocol_cnt++;
                end else begin
                    rec = '{hart: core_pkg::hart_t'(f1), rd: core_pkg::reg_idx_t'(f2),
                            value: f3};
                    exp_q[rec.hart].push_back(rec);
                    n_exp++;
                end
            end
        end
        $fclose(fd);
    endtask

    // One word per cycle, imem and dmem share the address and data fields
    task automatic load_memories();
        foreach (load_q[k]) begin
            @(posedge clk);
            #drive_dly;
            imem_we    = load_q[k].is_imem;
            dmem_we    = !load_q[k].is_imem;
            imem_addr  = core_pkg::imem_addr_t'(load_q[k].addr);
            dmem_addr  = core_pkg::dmem_addr_t'(load_q[k].addr);
            imem_wdata = load_q[k].data;
            dmem_wdata = load_q[k].data;
        end
        @(posedge clk);
        #drive_dly;
        imem_we   = 1'b0;
        dmem_we   = 1'b0;
        prog_mode = 1'b0;
    endtask

    function automatic bit queues_empty();
        for (int h = 0; h < `NUM_HARTS; h++) begin
            if (exp_q[h].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic report_leftovers();
        for (int h = 0; h < `NUM_HARTS; h++) begin
            if (exp_q[h].size() != 0) begin
                $display("Hart %0d never retired %0d expected records", h, exp_q[h].size());
                missing_cnt += exp_q[h].size();
            end
        end
    endtask

    // ==========================================================
    // Retire monitor, sampled mid-cycle
    // ==========================================================
    always @(negedge clk) begin : retire_monitor
        core_pkg::retire_t want;
        if (retire_valid) begin
            if (prog_mode || !arst_n) begin
                $display("Retire at %0t while reset or program mode was active", $time);
                protocol_cnt++;
            end
            if (retire.rd == '0) begin
                $display("Write to x0 retired at %0t on hart %0d", $time, retire.hart);
                protocol_cnt++;
            end
            // Fetched in slot t, retired in slot t+4, which belongs to the same hart
            if (retire.hart !== core_pkg::hart_t'(slot_cnt % `NUM_HARTS)) begin
                $display("[ERROR] %0t retire.hart expected %0d got %0d",
                         $time, slot_cnt % `NUM_HARTS, retire.hart);
                mismatch_cnt++;
            end
            // One instruction in flight per hart, so at most one retire per rotation
            if (cycle_cnt - last_retire[retire.hart] < `NUM_HARTS) begin
                $display("Hart %0d retired twice within one rotation at %0t",
                         retire.hart, $time);
                protocol_cnt++;
            end
            last_retire[retire.hart] = cycle_cnt;
            if (exp_q[retire.hart].size() == 0) begin
                $display("Unexpected retire at %0t: hart %0d x%0d = %h",
                         $time, retire.hart, retire.rd, retire.value);
                protocol_cnt++;
            end else begin
                want = exp_q[retire.hart].pop_front();
                if (retire.rd !== want.rd) begin
                    $display("[ERROR] %0t retire.rd hart %0d expected %0d got %0d",
                             $time, retire.hart, want.rd, retire.rd);
                    mismatch_cnt++;
                end
                if (retire.value !== want.value) begin
                    $display("[ERROR] %0t retire.value hart %0d expected %h got %h",
                             $time, retire.hart, want.value, retire.value);
                    mismatch_cnt++;
                end
            end
        end
    end

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        prog_mode    = 1'b1;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        dmem_we      = 1'b0;
        dmem_addr    = '0;
        dmem_wdata   = '0;
        cycle_cnt    = 0;
        n_exp        = 0;
        mismatch_cnt = 0;
        protocol_cnt = 0;
        missing_cnt  = 0;
        for (int h = 0; h < `NUM_HARTS; h++) begin
            last_retire[h] = -`NUM_HARTS;
        end
        read_testdata();
        // Reset, load, then two rotations per record plus slack
        cycle_limit = reset_cycles + load_q.size() + (n_exp + 4) * `NUM_HARTS * 2;
        repeat (reset_cycles) @(posedge clk);
        #drive_dly;
        arst_n = 1'b1;
        load_memories();
        // Harts end spinning on jal x0, a stray retire up to the limit still shows
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
        end
        if (!queues_empty()) begin
            $display("Cycle limit of %0d reached with retire records still pending",
                     cycle_limit);
            report_leftovers();
        end
        $display("Error counts: %0d mismatch, %0d protocol, %0d missing",
                 mismatch_cnt, protocol_cnt, missing_cnt);
        if (mismatch_cnt + protocol_cnt + missing_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/barrel_core_testdata.txt */
# Columns, all hex: I word_addr instr | D word_addr data | E hart rd value
# Text after # is a note; E lines are the retire records of each hart in order
# Hart 0 at word 00, arithmetic and LUI
I 00 00500093  # addi x1, x0, 5
I 01 ffd00113  # addi x2, x0, -3
I 02 002081b3  # add  x3, x1, x2
I 03 40208233  # sub  x4, x1, x2
I 04 0020c2b3  # xor  x5, x1, x2
I 05 00112333  # slt  x6, x2, x1
I 06 123453b7  # lui  x7, 0x12345
I 07 0020f433  # and  x8, x1, x2
I 08 0020e4b3  # or   x9, x1, x2
I 09 00700013  # addi x0, x0, 7, must not retire
I 0a 0000006f  # jal  x0, 0
E 0 1 00000005
E 0 2 fffffffd
E 0 3 00000002
E 0 4 00000008
E 0 5 fffffff8
E 0 6 00000001
E 0 7 12345000
E 0 8 00000005
E 0 9 fffffffd
# Hart 1 at word 10, loads and stores
I 10 0a000093  # addi x1, x0, 160
I 11 0000a103  # lw   x2, 0(x1)
I 12 abcde1b7  # lui  x3, 0xabcde
I 13 12318193  # addi x3, x3, 0x123
I 14 0030a223  # sw   x3, 4(x1)
I 15 0040a203  # lw   x4, 4(x1)
I 16 0000006f  # jal  x0, 0
D 28 cafef00d  # byte address 160
E 1 1 000000a0
E 1 2 cafef00d
E 1 3 abcde000
E 1 3 abcde123
E 1 4 abcde123
# Hart 2 at word 20, branches and JAL
I 20 00100093  # addi x1, x0, 1
I 21 00100113  # addi x2, x0, 1
I 22 00208463  # beq  x1, x2, +8, taken
I 23 06300193  # addi x3, x0, 99, skipped
I 24 00209463  # bne  x1, x2, +8, falls through
I 25 00400213  # addi x4, x0, 4
I 26 00009463  # bne  x1, x0, +8, taken
I 27 03700293  # addi x5, x0, 55, skipped
I 28 008003ef  # jal  x7, +8 from byte 160
I 29 05800413  # addi x8, x0, 88, skipped
I 2a 0000006f  # jal  x0, 0
E 2 1 00000001
E 2 2 00000001
E 2 4 00000004
E 2 7 000000a4
# Hart 3 at word 30, signed compare and a preloaded word
I 30 800000b7  # lui  x1, 0x80000
I 31 00100113  # addi x2, x0, 1
I 32 0020a1b3  # slt  x3, x1, x2
I 33 0c800313  # addi x6, x0, 200
I 34 00032383  # lw   x7, 0(x6)
I 35 0000006f  # jal  x0, 0
D 32 0badbeef  # byte address 200
E 3 1 80000000
E 3 2 00000001
E 3 3 00000001
E 3 6 000000c8
E 3 7 0badbeef

/* vlog.f */
+incdir+include
src/rv_isa_pkg.sv
src/core_pkg.sv
src/fetch_unit.sv
src/hart_regfile.sv
src/decode_stage.sv
src/execute_stage.sv
src/data_mem.sv
src/writeback_stage.sv
src/barrel_core_top.sv
verification/tb_barrel_core.sv

/* Makefile */
# Verilator build and run for the barrel core testbench
VERILATOR  ?= verilator
TOP        ?= tb_barrel_core
RTL_TOP    ?= barrel_core_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Testbench passed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
